/* fetch_macros.svh */
//*************************************************
// Fetch front end constants: line, beat, buffer,
// window sizes, refill threshold and request tag
//*************************************************
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// one bus line read
`define FETCH_LINE_BYTES 64
`define BEAT_BYTES 8
`define BEATS_PER_LINE 8

// circular decode buffer
`define BUFFER_BYTES 128
`define WINDOW_BYTES 15

// no new line read once this many bytes wait in the buffer
`define REFILL_THRESHOLD 32

// request tag fields, direction then space
`define TAG_READ 1'b1
`define TAG_MEMORY 4'h1

`endif

/* fetchPkg.sv */
//*************************************************
// Fetch front end types: bus, buffer and window
// vectors plus the fetch FSM states
//*************************************************
`include "fetch_macros.svh"

package fetchPkg;

   typedef logic [63:0] addrT;

   // byte k of a beat sits in bits 8k+7 down to 8k
   typedef logic [`BEAT_BYTES*8-1:0] beatT;

   // direction, space, eight zero bits
   typedef logic [12:0] reqTagT;

   // wraps modulo the buffer size
   typedef logic [$clog2(`BUFFER_BYTES)-1:0] bufOffsetT;

   // beat index inside a line, also the skip count
   typedef logic [$clog2(`BEATS_PER_LINE)-1:0] beatCountT;

   // 0 to 15 bytes consumed per cycle
   typedef logic [3:0] byteCountT;

   typedef logic [`WINDOW_BYTES*8-1:0] windowT;

   typedef enum logic [1:0] {
      fetchIdle,
      fetchWaiting,
      fetchActive
   } fetchStateT;

endpackage

/* busRequester.sv */
//*************************************************
// Bus requester: issues line reads, walks the
// fetch address and drops beats before the entry
//*************************************************
`include "fetch_macros.svh"

module busRequester
   import fetchPkg::*;
(
   input  logic       bus,
   input  logic       rst,
   input  addrT       entry,
   input  bufOffsetT  fillLevel,
   output logic       reqCyc,
   output addrT       req,
   output reqTagT     reqTag,
   input  logic       reqAck,
   input  logic       respCyc,
   input  beatT       resp,
   output logic       beatWrite,
   output beatT       beatData
);

   fetchStateT state;
   addrT       fetchAddr;
   beatCountT  skipCount;
   logic       sendReq;
   addrT       lineMask;

   assign lineMask = ~addrT'(`FETCH_LINE_BYTES - 1);

   // only one line in flight, and only while the buffer runs low
   always_comb begin
      if (state != fetchIdle) begin
         sendReq = 1'b0;
      end else if (reqAck) begin
         sendReq = 1'b0;
      end else begin
         sendReq = (fillLevel < bufOffsetT'(`REFILL_THRESHOLD));
      end
   end

   // beats ahead of the entry point never reach the buffer
   assign beatWrite = respCyc && (skipCount == '0);
   assign beatData  = resp;

   always_ff @(posedge bus) begin
      if (rst) begin
         reqCyc <= 1'b0;
      end else begin
         reqCyc <= sendReq;
      end
   end

   // request address and tag
   always_ff @(posedge bus) begin
      req    <= fetchAddr & lineMask;
      reqTag <= {`TAG_READ, `TAG_MEMORY, 8'h00};
   end

   // fetch FSM
   always_ff @(posedge bus) begin
      if (rst) begin
         state     <= fetchIdle;
         fetchAddr <= entry & lineMask;
         // entry is beat aligned, so bits 5..3 count the beats to drop
         skipCount <= entry[5:3];
      end else begin
         if (respCyc) begin
            state     <= fetchActive;
            fetchAddr <= fetchAddr + addrT'(`BEAT_BYTES);
            if (skipCount != '0) begin
               skipCount <= skipCount - beatCountT'(1);
            end
         end else begin
            case (state)
               fetchActive: begin
                  // first gap after the beats ends the line
                  state <= fetchIdle;
               end
               fetchIdle: begin
                  if (reqAck) begin
                     state <= fetchWaiting;
                  end
               end
               default: begin
                  // waiting for the first beat
                  state <= state;
               end
            endcase
         end
      end
   end

endmodule

/* lineBuffer.sv */
//*************************************************
// Line buffer: 128-byte circular decode storage
// with fill level and wrapped window extraction
//*************************************************
`include "fetch_macros.svh"

module lineBuffer
   import fetchPkg::*;
(
   input  logic      bus,
   input  logic      rst,
   input  logic      beatWrite,
   input  beatT      beatData,
   input  bufOffsetT readOffset,
   output bufOffsetT fillLevel,
   output windowT    window
);

   // byte i of the buffer sits in bits 8i+7 down to 8i
   logic [`BUFFER_BYTES*8-1:0] bufferBits;
   bufOffsetT                  writeOffset;

   // first window's worth of bytes repeated above the top
   logic [(`BUFFER_BYTES+`WINDOW_BYTES)*8-1:0] bufferWrapped;

   logic [$clog2(`BUFFER_BYTES*8)-1:0] writeBit;
   logic [$clog2(`BUFFER_BYTES*8)-1:0] readBit;

   assign writeBit = {writeOffset, 3'b000};
   assign readBit  = {readOffset, 3'b000};

   // beat data storage
   always_ff @(posedge bus) begin
      if (beatWrite) begin
         bufferBits[writeBit +: `BEAT_BYTES*8] <= beatData;
      end
   end

   // write pointer
   always_ff @(posedge bus) begin
      if (rst) begin
         writeOffset <= '0;
      end else if (beatWrite) begin
         writeOffset <= writeOffset + bufOffsetT'(`BEAT_BYTES);
      end
   end

   // modulo 128 difference gives the bytes not yet consumed
   assign fillLevel = writeOffset - readOffset;

   assign bufferWrapped = {bufferBits[`WINDOW_BYTES*8-1:0], bufferBits};

   // a window starting near byte 127 runs on into bytes 0, 1, ...
   assign window = bufferWrapped[readBit +: `WINDOW_BYTES*8];

endmodule

/* decodeCursor.sv */
//*************************************************
// Decode cursor: read offset, window valid level
// and the current instruction pointer
//*************************************************
`include "fetch_macros.svh"

module decodeCursor
   import fetchPkg::*;
(
   input  logic      bus,
   input  logic      rst,
   input  addrT      entry,
   input  bufOffsetT fillLevel,
   input  byteCountT bytesTaken,
   output bufOffsetT readOffset,
   output logic      windowValid,
   output addrT      currentRip
);

   // a full window must be buffered before the decoder may consume
   assign windowValid = (fillLevel >= bufOffsetT'(`WINDOW_BYTES));

   always_ff @(posedge bus) begin
      if (rst) begin
         readOffset <= '0;
         currentRip <= entry;
      end else if (windowValid) begin
         // offset wraps with the buffer, rip keeps counting
         readOffset <= readOffset + bufOffsetT'(bytesTaken);
         currentRip <= currentRip + addrT'(bytesTaken);
      end
   end

endmodule

/* fetchTop.sv */
//*************************************************
// Fetch front end top: bus requester, line buffer
// and decode cursor between system bus and decoder
//*************************************************
`include "fetch_macros.svh"

module fetchTop
   import fetchPkg::*;
(
   input  logic      bus,
   input  logic      rst,
   input  addrT      entry,
   // system bus request side
   output logic      reqCyc,
   output addrT      req,
   output reqTagT    reqTag,
   input  logic      reqAck,
   // system bus response side
   input  logic      respCyc,
   input  beatT      resp,
   output logic      respAck,
   // decoder side
   input  byteCountT bytesTaken,
   output windowT    window,
   output logic      windowValid,
   output addrT      currentRip
);

   logic      beatWrite;
   beatT      beatData;
   bufOffsetT fillLevel;
   bufOffsetT readOffset;

   // response data is always accepted
   assign respAck = respCyc;

   busRequester busRequester_inst (
      .bus       (bus),
      .rst       (rst),
      .entry     (entry),
      .fillLevel (fillLevel),
      .reqCyc    (reqCyc),
      .req       (req),
      .reqTag    (reqTag),
      .reqAck    (reqAck),
      .respCyc   (respCyc),
      .resp      (resp),
      .beatWrite (beatWrite),
      .beatData  (beatData)
   );

   lineBuffer lineBuffer_inst (
      .bus        (bus),
      .rst        (rst),
      .beatWrite  (beatWrite),
      .beatData   (beatData),
      .readOffset (readOffset),
      .fillLevel  (fillLevel),
      .window     (window)
   );

   decodeCursor decodeCursor_inst (
      .bus         (bus),
      .rst         (rst),
      .entry       (entry),
      .fillLevel   (fillLevel),
      .bytesTaken  (bytesTaken),
      .readOffset  (readOffset),
      .windowValid (windowValid),
      .currentRip  (currentRip)
   );

endmodule

/* memoryModel.sv */
//*************************************************
// Memory model: acknowledges line reads and
// returns eight beats of patterned memory per line
//*************************************************
`include "fetch_macros.svh"

module memoryModel
   import fetchPkg::*;
(
   input  logic   bus,
   input  logic   rst,
   input  logic   reqCyc,
   input  addrT   req,
   input  reqTagT reqTag,
   output logic   reqAck,
   output logic   respCyc,
   output beatT   resp,
   output logic   reqSeen,
   output addrT   reqAddr,
   output reqTagT reqTagSeen
);
   timeunit 1ns;
   timeprecision 100ps;

   typedef enum {memIdle, memAckWait, memLatency, memBeats} memPhaseT;

   memPhaseT    phase = memIdle;
   logic [31:0] seed = 32'h4d74e5e0;
   int          latency = 0;
   int          beatIndex = 0;
   logic        resetSeen;
   logic        cycSeen;
   addrT        addrSeen;
   reqTagT      tagSeen;

   function automatic logic [31:0] nextRandom(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   // memory byte a holds a[7:0] ^ a[15:8] ^ 5a
   function automatic logic [7:0] byteAt(input addrT a);
      return a[7:0] ^ a[15:8] ^ 8'h5a;
   endfunction

   function automatic beatT beatAt(input addrT base);
      beatT b;
      for (int k = 0; k < `BEAT_BYTES; k++) begin
         b[k*8 +: 8] = byteAt(base + addrT'(k));
      end
      return b;
   endfunction

   initial begin
      reqAck     = 1'b0;
      respCyc    = 1'b0;
      resp       = '0;
      reqSeen    = 1'b0;
      reqAddr    = '0;
      reqTagSeen = '0;
   end

   always @(posedge bus) begin
      // inputs taken at the edge, outputs changed just after it
      resetSeen = rst;
      cycSeen   = reqCyc;
      addrSeen  = req;
      tagSeen   = reqTag;
      #1;
      reqAck  = 1'b0;
      reqSeen = 1'b0;
      if (resetSeen) begin
         phase   = memIdle;
         respCyc = 1'b0;
      end else begin
         case (phase)
            memIdle: begin
               if (cycSeen) begin
                  reqSeen    = 1'b1;
                  reqAddr    = addrSeen;
                  reqTagSeen = tagSeen;
                  phase      = memAckWait;
               end
            end
            memAckWait: begin
               reqAck  = 1'b1;
               seed    = nextRandom(seed);
               // 3 to 6 cycles before the first beat
               latency = 3 + int'(seed[17:16]);
               phase   = memLatency;
            end
            memLatency: begin
               latency--;
               if (latency == 0) begin
                  respCyc   = 1'b1;
                  resp      = beatAt(reqAddr);
                  beatIndex = 1;
                  phase     = memBeats;
               end
            end
            default: begin
               if (beatIndex == `BEATS_PER_LINE) begin
                  respCyc = 1'b0;
                  phase   = memIdle;
               end else begin
                  resp = beatAt(reqAddr + addrT'(beatIndex * `BEAT_BYTES));
                  beatIndex++;
               end
            end
         endcase
      end
   end

endmodule

/* fetchTopTb.sv */
//*************************************************
// Fetch front end testbench with directed tests
// for reset, requests, entry skip, streaming, stalls
//*************************************************
module fetchTopTb
   import fetchPkg::*;
;
   timeunit 1ns;
   timeprecision 100ps;

   logic      bus = 1'b0;
   logic      rst;
   addrT      entry;
   logic      reqCyc;
   addrT      req;
   reqTagT    reqTag;
   logic      reqAck;
   logic      respCyc;
   beatT      resp;
   logic      respAck;
   byteCountT bytesTaken;
   windowT    window;
   logic      windowValid;
   addrT      currentRip;
   logic      reqSeen;
   addrT      reqAddr;
   reqTagT    reqTagSeen;

   int          errorCount = 0;
   int          timeoutCount = 0;
   logic [31:0] seed = 32'h4d74e5e0;

   // request log filled by the monitor below
   addrT   reqAddrLog [0:63];
   reqTagT reqTagLog [0:63];
   int     reqKeptLog [0:63];
   int     requestCount = 0;
   int     beatsSeen = 0;
   int     skipBeats;

   always #4 bus = ~bus;

   fetchTop fetchTop_inst (
      .bus         (bus),
      .rst         (rst),
      .entry       (entry),
      .reqCyc      (reqCyc),
      .req         (req),
      .reqTag      (reqTag),
      .reqAck      (reqAck),
      .respCyc     (respCyc),
      .resp        (resp),
      .respAck     (respAck),
      .bytesTaken  (bytesTaken),
      .window      (window),
      .windowValid (windowValid),
      .currentRip  (currentRip)
   );

   memoryModel memoryModel_inst (
      .bus        (bus),
      .rst        (rst),
      .reqCyc     (reqCyc),
      .req        (req),
      .reqTag     (reqTag),
      .reqAck     (reqAck),
      .respCyc    (respCyc),
      .resp       (resp),
      .reqSeen    (reqSeen),
      .reqAddr    (reqAddr),
      .reqTagSeen (reqTagSeen)
   );

   function automatic logic [31:0] nextRandom(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic logic [7:0] expectedByte(input addrT a);
      return a[7:0] ^ a[15:8] ^ 8'h5a;
   endfunction

   task automatic compareValue(input logic [127:0] actual, input logic [127:0] expected,
                               input string what);
      if (actual !== expected) begin
         errorCount++;
         $display("ERROR %0t: %s is %0h, expected %0h", $time, what, actual, expected);
      end
   endtask

   // logs each request with the bytes kept so far in this run
   always @(negedge bus) begin
      if (rst) begin
         beatsSeen    = 0;
         requestCount = 0;
      end else begin
         if (reqSeen && requestCount < 64) begin
            skipBeats = int'(entry[5:3]);
            reqAddrLog[requestCount] = reqAddr;
            reqTagLog[requestCount]  = reqTagSeen;
            reqKeptLog[requestCount] = (beatsSeen > skipBeats) ? (beatsSeen - skipBeats) * 8 : 0;
            requestCount++;
         end
         if (respCyc) begin
            beatsSeen++;
         end
      end
   end

   task automatic holdReset(input addrT newEntry);
      @(posedge bus);
      #1;
      rst        = 1'b1;
      entry      = newEntry;
      bytesTaken = '0;
      repeat (8) @(posedge bus);
      #1;
   endtask

   task automatic waitWindowValid(input string testName);
      int cycles;
      cycles = 0;
      while (windowValid !== 1'b1 && cycles < 200) begin
         @(posedge bus);
         #1;
         cycles++;
      end
      if (windowValid !== 1'b1) begin
         timeoutCount++;
         $display("%s: timed out waiting for windowValid", testName);
      end
   endtask

   task automatic checkWindow(input string testName, input addrT base);
      for (int i = 0; i < 15; i++) begin
         compareValue(128'(window[i*8 +: 8]), 128'(expectedByte(base + addrT'(i))),
                      $sformatf("%s window byte %0d at rip %0h", testName, i, base));
      end
   endtask

   // lines follow each other 64 bytes apart from the entry line
   task automatic checkRequests(input string testName, input logic backPressure);
      addrT line;
      line = entry & ~addrT'(63);
      if (requestCount == 0) begin
         errorCount++;
         $display("%s: the DUT never issued a line request", testName);
      end
      for (int i = 0; i < requestCount; i++) begin
         compareValue(128'(reqAddrLog[i]), 128'(line),
                      $sformatf("%s request %0d address", testName, i));
         compareValue(128'(reqTagLog[i]), 128'({1'b1, 4'h1, 8'h00}),
                      $sformatf("%s request %0d tag", testName, i));
         if (backPressure && reqKeptLog[i] >= 32) begin
            errorCount++;
            $display("ERROR %0t: %s request %0d issued with %0d bytes buffered",
                     $time, testName, i, reqKeptLog[i]);
         end
         line = line + 64'd64;
      end
   endtask

   task automatic checkIdleOutputs(input string when);
      compareValue(128'(reqCyc), 128'(0), {"reqCyc ", when});
      compareValue(128'(windowValid), 128'(0), {"windowValid ", when});
      compareValue(128'(currentRip), 128'(entry), {"currentRip ", when});
   endtask

   task automatic testReset();
      holdReset(64'h1000);
      checkIdleOutputs("in reset");
      rst = 1'b0;
      @(negedge bus);
      checkIdleOutputs("right after reset");
   endtask

   task automatic testEntry(input addrT newEntry, input string testName);
      holdReset(newEntry);
      rst = 1'b0;
      waitWindowValid(testName);
      compareValue(128'(currentRip), 128'(newEntry), {testName, " currentRip"});
      checkWindow(testName, newEntry);
      checkRequests(testName, 1'b0);
   endtask

   task automatic testStreaming();
      addrT      expectedRip;
      int        consumed;
      int        cycles;
      byteCountT take;
      holdReset(64'h7ff0);
      rst         = 1'b0;
      expectedRip = 64'h7ff0;
      consumed    = 0;
      cycles      = 0;
      // 640 bytes wrap the 128-byte buffer five times
      while (consumed < 640 && cycles < 4000) begin
         @(posedge bus);
         #1;
         cycles++;
         compareValue(128'(currentRip), 128'(expectedRip), "streaming currentRip");
         if (windowValid) begin
            checkWindow("streaming", expectedRip);
            seed        = nextRandom(seed);
            take        = seed[19:16] % 4'd15 + 4'd1;
            bytesTaken  = take;
            expectedRip = expectedRip + addrT'(take);
            consumed    = consumed + int'(take);
         end else begin
            bytesTaken = '0;
         end
      end
      @(posedge bus);
      #1;
      bytesTaken = '0;
      if (consumed < 640) begin
         timeoutCount++;
         $display("streaming: only %0d bytes consumed before the timeout", consumed);
      end
      compareValue(128'(currentRip), 128'(expectedRip), "streaming final currentRip");
      checkRequests("streaming", 1'b0);
   endtask

   task automatic testBackPressure();
      windowT held;
      holdReset(64'h9028);
      rst = 1'b0;
      waitWindowValid("back-pressure");
      checkWindow("back-pressure", entry);
      held = window;
      for (int cycle = 0; cycle < 60; cycle++) begin
         @(negedge bus);
         compareValue(128'(respAck), 128'(respCyc), "back-pressure respAck");
         compareValue(128'(window), 128'(held), "back-pressure window");
      end
      compareValue(128'(currentRip), 128'(entry), "back-pressure currentRip");
      // 24 bytes after the first line, 88 after the second
      compareValue(128'(requestCount), 128'(2), "back-pressure request count");
      checkRequests("back-pressure", 1'b1);
   endtask

   initial begin
      rst        = 1'b1;
      entry      = 64'h1000;
      bytesTaken = '0;
      testReset();
      testEntry(64'h2000, "aligned entry");
      testEntry(64'h3028, "entry inside line");
      testStreaming();
      testBackPressure();
      $display("errors: %0d, timeouts: %0d", errorCount, timeoutCount);
      if (errorCount == 0 && timeoutCount == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

/* fetchTop.f */
+incdir+.
fetchPkg.sv
busRequester.sv
lineBuffer.sv
decodeCursor.sv
fetchTop.sv
memoryModel.sv
fetchTopTb.sv

/* run.sh */
#!/bin/sh
# compile the fetch front end with its testbench under Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f fetchTop.f --top-module fetchTopTb -o fetchSim \
   || { echo "compile failed"; exit 1; }
./obj_dir/fetchSim | tee /dev/stderr | grep -qxF '** PASS **' \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
